// ==== verilog/mandel_pkg.sv ====
package mandel_pkg;

	// fixed-point format, signed Q10.10
	localparam int DATA_W = 20;
	localparam int FRAC_W = 10;
	// iteration count width
	localparam int ITER_W = 8;

	// frame geometry
	localparam int FRAME_W = 16;
	localparam int FRAME_H = 8;
	localparam int ADDR_W = 7;
	localparam int N_PIXELS = FRAME_W * FRAME_H;

	typedef logic signed [DATA_W-1:0] fixed_t;

	// 4.0 in Q10.10
	localparam fixed_t ESCAPE_LIMIT = 20'sd4096;

	// per-frame setup, latched on start
	typedef struct packed {
		fixed_t re0;
		fixed_t im0;
		fixed_t step;
		logic [ITER_W-1:0] max_iter;
	} frame_cfg_t;

	// one pixel of work, addr is y*16 + x
	typedef struct packed {
		fixed_t c_re;
		fixed_t c_im;
		logic [ADDR_W-1:0] addr;
	} pixel_job_t;

	// wishbone classic master side
	typedef struct packed {
		logic cyc;
		logic stb;
		logic we;
		logic [ADDR_W-1:0] adr;
		logic [ITER_W-1:0] dat;
	} wb_req_t;

	// slave side, write-only so just ack
	typedef struct packed {
		logic ack;
	} wb_rsp_t;

endpackage

// ==== verilog/mandel_iter_core.sv ====
`timescale 1ns/1ps

module mandel_iter_core (
	input  logic                          tb_clk,
	input  logic                          arst_n,
	input  mandel_pkg::pixel_job_t        job,
	input  logic                          job_valid,
	input  logic [mandel_pkg::ITER_W-1:0] max_iter,
	output logic                          job_ready,
	output mandel_pkg::wb_req_t           wb_req,
	input  mandel_pkg::wb_rsp_t           wb_rsp
);
	import mandel_pkg::*;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_ITER,
		ST_WRITE
	} state_t;

	state_t state;

	// current job
	fixed_t c_re;
	fixed_t c_im;
	logic [ADDR_W-1:0] addr;
	// z plus its squares, squares already back in Q10.10
	fixed_t z_re;
	fixed_t z_im;
	fixed_t sq_re;
	fixed_t sq_im;
	logic [ITER_W-1:0] count;

	// full-width products
	logic signed [2*DATA_W-1:0] p_ri;
	logic signed [2*DATA_W-1:0] p_nre;
	logic signed [2*DATA_W-1:0] p_nim;
	fixed_t ri;
	fixed_t nz_re;
	fixed_t nz_im;
	fixed_t nsq_re;
	fixed_t nsq_im;
	// one extra bit so two squares near the limit cannot wrap
	logic signed [DATA_W:0] mag;
	logic [ITER_W-1:0] count_nxt;
	logic stop;

	// z^2 real part reuses the squares kept from last cycle,
	// so only zr*zi and the two new squares need multipliers
	always_comb
	begin
		p_ri = z_re * z_im;
		ri = p_ri[FRAC_W +: DATA_W];
		nz_re = sq_re - sq_im + c_re;
		nz_im = ri + ri + c_im;
		p_nre = nz_re * nz_re;
		p_nim = nz_im * nz_im;
		nsq_re = p_nre[FRAC_W +: DATA_W];
		nsq_im = p_nim[FRAC_W +: DATA_W];
		// size of the new z
		mag = nsq_re + nsq_im;
		count_nxt = count + 1'b1;
		stop = (mag > ESCAPE_LIMIT) || (count_nxt == max_iter);
	end

	assign job_ready = (state == ST_IDLE);

	// request held straight from state, stable until ack
	always_comb
	begin
		wb_req.cyc = (state == ST_WRITE);
		wb_req.stb = (state == ST_WRITE);
		wb_req.we = (state == ST_WRITE);
		wb_req.adr = addr;
		wb_req.dat = count;
	end

	always_ff @(posedge tb_clk or negedge arst_n)
	begin
		if (!arst_n)
			state <= ST_IDLE;
		else
		begin
			case (state)
				ST_IDLE:
					if (job_valid)
						state <= ST_ITER;
				ST_ITER:
					if (stop)
						state <= ST_WRITE;
				ST_WRITE:
					// cyc drops the cycle after ack
					if (wb_rsp.ack)
						state <= ST_IDLE;
				default:
					state <= ST_IDLE;
			endcase
		end
	end

	always_ff @(posedge tb_clk)
	begin
		if (job_valid && job_ready)
		begin
			c_re <= job.c_re;
			c_im <= job.c_im;
			addr <= job.addr;
			// iteration starts from z = 0
			z_re <= '0;
			z_im <= '0;
			sq_re <= '0;
			sq_im <= '0;
			count <= '0;
		end
		else if (state == ST_ITER)
		begin
			z_re <= nz_re;
			z_im <= nz_im;
			sq_re <= nsq_re;
			sq_im <= nsq_im;
			count <= count_nxt;
		end
	end

endmodule

// ==== verilog/mandel_scan_sched.sv ====
`timescale 1ns/1ps

module mandel_scan_sched (
	input  logic                          tb_clk,
	input  logic                          arst_n,
	input  logic                          start,
	input  mandel_pkg::frame_cfg_t        cfg,
	input  logic [1:0]                    eng_ready,
	output logic [1:0]                    eng_valid,
	output mandel_pkg::pixel_job_t        job,
	input  logic                          wr_done,
	output logic [mandel_pkg::ITER_W-1:0] max_iter,
	output logic                          busy,
	output logic                          done
);
	import mandel_pkg::*;

	frame_cfg_t cfg_q;
	// raster position of the next job
	logic [$clog2(FRAME_W)-1:0] x;
	logic [$clog2(FRAME_H)-1:0] y;
	// c of the next job
	fixed_t cur_re;
	fixed_t cur_im;
	// still jobs left to hand out
	logic issuing;
	logic [ADDR_W:0] wr_cnt;
	logic take;
	logic fire;
	logic row_end;

	assign take = start && !busy;
	// engine 0 first, engine 1 only offered when 0 is busy
	assign eng_valid[0] = issuing;
	assign eng_valid[1] = issuing && !eng_ready[0];
	assign fire = |(eng_valid & eng_ready);
	assign row_end = (x == FRAME_W - 1);

	assign job.c_re = cur_re;
	assign job.c_im = cur_im;
	assign job.addr = {y, x};
	assign max_iter = cfg_q.max_iter;

	always_ff @(posedge tb_clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			x <= '0;
			y <= '0;
			issuing <= 1'b0;
			wr_cnt <= '0;
			busy <= 1'b0;
			done <= 1'b0;
		end
		else if (take)
		begin
			x <= '0;
			y <= '0;
			issuing <= 1'b1;
			wr_cnt <= '0;
			busy <= 1'b1;
			done <= 1'b0;
		end
		else
		begin
			// counters hold while no engine takes the job
			if (fire)
			begin
				x <= row_end ? '0 : x + 1'b1;
				if (row_end)
				begin
					y <= y + 1'b1;
					if (y == FRAME_H - 1)
						issuing <= 1'b0;
				end
			end
			// frame ends on the last acked write
			if (wr_done && busy)
			begin
				wr_cnt <= wr_cnt + 1'b1;
				if (wr_cnt == N_PIXELS - 1)
				begin
					busy <= 1'b0;
					done <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge tb_clk)
	begin
		if (take)
		begin
			cfg_q <= cfg;
			cur_re <= cfg.re0;
			cur_im <= cfg.im0;
		end
		else if (fire)
		begin
			// next row restarts at re0, one step down in im
			if (row_end)
			begin
				cur_re <= cfg_q.re0;
				cur_im <= cur_im + cfg_q.step;
			end
			else
				cur_re <= cur_re + cfg_q.step;
		end
	end

endmodule

// ==== verilog/wb_rr_arbiter.sv ====
`timescale 1ns/1ps

module wb_rr_arbiter (
	input  logic                tb_clk,
	input  logic                arst_n,
	input  mandel_pkg::wb_req_t m_req [2],
	output mandel_pkg::wb_rsp_t m_rsp [2],
	output mandel_pkg::wb_req_t s_req,
	input  mandel_pkg::wb_rsp_t s_rsp
);

	// bus owned by gnt_idx while gnt_act
	logic gnt_act;
	logic gnt_idx;
	// master served most recently
	logic last;

	always_ff @(posedge tb_clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			gnt_act <= 1'b0;
			gnt_idx <= 1'b0;
			// master 0 wins the first tie
			last <= 1'b1;
		end
		else if (gnt_act)
		begin
			// owner let go of cyc
			if (!m_req[gnt_idx].cyc)
			begin
				last <= gnt_idx;
				if (m_req[~gnt_idx].cyc)
					gnt_idx <= ~gnt_idx;
				else
					gnt_act <= 1'b0;
			end
		end
		else if (m_req[0].cyc || m_req[1].cyc)
		begin
			gnt_act <= 1'b1;
			// the one not served last goes first
			gnt_idx <= m_req[~last].cyc ? ~last : last;
		end
	end

	// granted request to the slave, idle bus otherwise
	assign s_req = gnt_act ? m_req[gnt_idx] : '0;

	// ack only to the owner
	assign m_rsp[0].ack = gnt_act && !gnt_idx && s_rsp.ack;
	assign m_rsp[1].ack = gnt_act && gnt_idx && s_rsp.ack;

endmodule

// ==== verilog/frame_ram.sv ====
`timescale 1ns/1ps

module frame_ram (
	input  logic                          tb_clk,
	input  logic                          arst_n,
	input  mandel_pkg::wb_req_t           wb_req,
	output mandel_pkg::wb_rsp_t           wb_rsp,
	output logic                          wr_done,
	input  logic [mandel_pkg::ADDR_W-1:0] rd_addr,
	output logic [mandel_pkg::ITER_W-1:0] rd_data
);
	import mandel_pkg::*;

	logic [ITER_W-1:0] mem [N_PIXELS];
	logic ack_q;
	// new strobe, not the one already being acked
	logic take;

	assign take = wb_req.cyc && wb_req.stb && !ack_q;

	// single-cycle ack after each strobe
	always_ff @(posedge tb_clk or negedge arst_n)
	begin
		if (!arst_n)
			ack_q <= 1'b0;
		else
			ack_q <= take;
	end

	always_ff @(posedge tb_clk)
	begin
		// write lands on the edge that raises ack
		if (take && wb_req.we)
			mem[wb_req.adr] <= wb_req.dat;
		// host side, one edge of latency
		rd_data <= mem[rd_addr];
	end

	assign wb_rsp.ack = ack_q;
	// we still held by the master during the ack cycle
	assign wr_done = ack_q && wb_req.we;

endmodule

// ==== verilog/mandel_renderer.sv ====
`timescale 1ns/1ps

module mandel_renderer (
	input  logic                          tb_clk,
	input  logic                          arst_n,
	input  logic                          start,
	input  mandel_pkg::frame_cfg_t        cfg,
	output logic                          busy,
	output logic                          done,
	input  logic [mandel_pkg::ADDR_W-1:0] rd_addr,
	output logic [mandel_pkg::ITER_W-1:0] rd_data
);
	import mandel_pkg::*;

	// job hand-off
	logic [1:0] eng_ready;
	logic [1:0] eng_valid;
	pixel_job_t job;
	logic [ITER_W-1:0] max_iter;
	logic wr_done;
	// engine side of the bus
	wb_req_t core_req [2];
	wb_rsp_t core_rsp [2];
	// memory side of the bus
	wb_req_t ram_req;
	wb_rsp_t ram_rsp;

	mandel_scan_sched u_sched (
		.tb_clk    (tb_clk),
		.arst_n    (arst_n),
		.start     (start),
		.cfg       (cfg),
		.eng_ready (eng_ready),
		.eng_valid (eng_valid),
		.job       (job),
		.wr_done   (wr_done),
		.max_iter  (max_iter),
		.busy      (busy),
		.done      (done)
	);

	// both engines see the same job, valid picks the taker
	mandel_iter_core u_core0 (
		.tb_clk    (tb_clk),
		.arst_n    (arst_n),
		.job       (job),
		.job_valid (eng_valid[0]),
		.max_iter  (max_iter),
		.job_ready (eng_ready[0]),
		.wb_req    (core_req[0]),
		.wb_rsp    (core_rsp[0])
	);

	mandel_iter_core u_core1 (
		.tb_clk    (tb_clk),
		.arst_n    (arst_n),
		.job       (job),
		.job_valid (eng_valid[1]),
		.max_iter  (max_iter),
		.job_ready (eng_ready[1]),
		.wb_req    (core_req[1]),
		.wb_rsp    (core_rsp[1])
	);

	wb_rr_arbiter u_arb (
		.tb_clk (tb_clk),
		.arst_n (arst_n),
		.m_req  (core_req),
		.m_rsp  (core_rsp),
		.s_req  (ram_req),
		.s_rsp  (ram_rsp)
	);

	frame_ram u_ram (
		.tb_clk  (tb_clk),
		.arst_n  (arst_n),
		.wb_req  (ram_req),
		.wb_rsp  (ram_rsp),
		.wr_done (wr_done),
		.rd_addr (rd_addr),
		.rd_data (rd_data)
	);

endmodule

// ==== dv/mandel_model.svh ====
`ifndef MANDEL_MODEL_SVH
`define MANDEL_MODEL_SVH

// c along one axis for pixel index idx
// built from repeated adds, so it wraps like a running 20-bit sum
function automatic fixed_t pixel_coord(input fixed_t origin, input fixed_t step, input int idx);
	fixed_t c;
	c = origin;
	for (int i = 0; i < idx; i++)
		c = c + step;
	return c;
endfunction

// Q10.10 product, shifted back by FRAC_W with sign, kept to 20 bits
function automatic fixed_t fx_mul(input fixed_t a, input fixed_t b);
	logic signed [2*DATA_W-1:0] p;
	p = a * b;
	return p[FRAC_W +: DATA_W];
endfunction

// escape-time count for one c, starting from z = 0
function automatic logic [ITER_W-1:0] escape_count(input fixed_t c_re, input fixed_t c_im,
	input logic [ITER_W-1:0] limit);
	fixed_t zr;
	fixed_t zi;
	fixed_t nzr;
	fixed_t nzi;
	// one bit wider than a value
	logic signed [DATA_W:0] size;
	logic [ITER_W-1:0] n;
	logic fin;
	zr = '0;
	zi = '0;
	n = '0;
	fin = 1'b0;
	while (!fin)
	begin
		// z^2 + c, every product truncated on its own
		nzr = fx_mul(zr, zr) - fx_mul(zi, zi) + c_re;
		nzi = fx_mul(zr, zi) + fx_mul(zr, zi) + c_im;
		zr = nzr;
		zi = nzi;
		size = fx_mul(zr, zr) + fx_mul(zi, zi);
		n = n + 1'b1;
		// escaped past 4.0, or limit hit
		fin = (size > ESCAPE_LIMIT) || (n == limit);
	end
	return n;
endfunction

`endif

// ==== dv/tb_mandel_renderer.sv ====
`timescale 1ns/1ps

module tb_mandel_renderer;
	import mandel_pkg::*;

	`include "mandel_model.svh"

	localparam int CLK_HALF = 4;
	localparam int RESET_CYCLES = 8;
	localparam int N_CASES = 4;

	// frame setup and the value every pixel must hold when has_fill is set
	typedef struct packed {
		frame_cfg_t cfg;
		logic has_fill;
		logic [ITER_W-1:0] fill;
	} frame_case_t;

	localparam frame_case_t CASES [N_CASES] = '{
		// full set view from -2.0 - 1.0i in steps of 0.1875
		'{cfg: '{re0: -20'sd2048, im0: -20'sd1024, step: 20'sd192, max_iter: 8'd32},
			has_fill: 1'b0, fill: 8'd0},
		// zoom on the seahorse edge from -0.75 + 0.05i in steps of 1/64
		'{cfg: '{re0: -20'sd768, im0: 20'sd51, step: 20'sd16, max_iter: 8'd255},
			has_fill: 1'b0, fill: 8'd0},
		// first iteration always ends it
		'{cfg: '{re0: -20'sd1536, im0: -20'sd512, step: 20'sd128, max_iter: 8'd1},
			has_fill: 1'b1, fill: 8'd1},
		// all inside the main cardioid so nothing escapes
		'{cfg: '{re0: -20'sd512, im0: -20'sd128, step: 20'sd16, max_iter: 8'd255},
			has_fill: 1'b1, fill: 8'd255}
	};

	logic tb_clk;
	logic arst_n;
	logic start;
	frame_cfg_t cfg;
	logic busy;
	logic done;
	logic [ADDR_W-1:0] rd_addr;
	logic [ITER_W-1:0] rd_data;
	// jobs taken by each engine since reset
	int jobs0 = 0;
	int jobs1 = 0;

	mandel_renderer u_dut (
		.tb_clk  (tb_clk),
		.arst_n  (arst_n),
		.start   (start),
		.cfg     (cfg),
		.busy    (busy),
		.done    (done),
		.rd_addr (rd_addr),
		.rd_data (rd_data)
	);

	always #CLK_HALF tb_clk = ~tb_clk;

	// hand-offs sampled between edges where valid and ready have settled
	always @(negedge tb_clk)
	begin
		if (u_dut.eng_valid[0] && u_dut.eng_ready[0])
			jobs0 <= jobs0 + 1;
		if (u_dut.eng_valid[1] && u_dut.eng_ready[1])
			jobs1 <= jobs1 + 1;
	end

	task automatic compare_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp)
		begin
			$display("Fail %s: got 0x%0h expected 0x%0h", name, got, exp);
			$display("TEST FAIL");
			$fatal(1, "mismatch on %s", name);
		end
	endtask

	// start pulse then follow busy until done
	task automatic run_frame(input frame_cfg_t fc);
		@(negedge tb_clk);
		cfg = fc;
		start = 1'b1;
		@(negedge tb_clk);
		start = 1'b0;
		compare_value("busy", busy, 1);
		compare_value("done", done, 0);
		while (!done)
		begin
			compare_value("busy", busy, 1);
			@(negedge tb_clk);
		end
		// done up and busy down on the same edge
		compare_value("busy", busy, 0);
	endtask

	// every address against the model with one read per cycle
	task automatic read_and_check_frame(input frame_case_t fcase);
		fixed_t c_re;
		fixed_t c_im;
		logic [ITER_W-1:0] exp_cnt;
		logic [ADDR_W-1:0] a;
		for (int y = 0; y < FRAME_H; y++)
		begin
			for (int x = 0; x < FRAME_W; x++)
			begin
				c_re = pixel_coord(fcase.cfg.re0, fcase.cfg.step, x);
				c_im = pixel_coord(fcase.cfg.im0, fcase.cfg.step, y);
				exp_cnt = escape_count(c_re, c_im, fcase.cfg.max_iter);
				a = ADDR_W'(y * FRAME_W + x);
				rd_addr = a;
				@(negedge tb_clk);
				compare_value($sformatf("rd_data[%0d]", a), rd_data, exp_cnt);
				if (fcase.has_fill)
					compare_value($sformatf("rd_data[%0d]", a), rd_data, fcase.fill);
			end
		end
	endtask

	initial
	begin
		int before0;
		int before1;
		tb_clk = 1'b0;
		arst_n = 1'b0;
		start = 1'b0;
		cfg = '0;
		rd_addr = '0;
		repeat (RESET_CYCLES) @(negedge tb_clk);
		compare_value("busy", busy, 0);
		compare_value("done", done, 0);
		arst_n = 1'b1;
		@(negedge tb_clk);
		compare_value("busy", busy, 0);
		compare_value("done", done, 0);
		// frames back to back so each must overwrite the whole memory
		for (int i = 0; i < N_CASES; i++)
		begin
			before0 = jobs0;
			before1 = jobs1;
			run_frame(CASES[i].cfg);
			compare_value("jobs issued", (jobs0 - before0) + (jobs1 - before1), N_PIXELS);
			compare_value("engine 0 used", (jobs0 - before0) != 0, 1);
			compare_value("engine 1 used", (jobs1 - before1) != 0, 1);
			read_and_check_frame(CASES[i]);
		end
		$display("TEST PASS");
		$finish;
	end

	// worst case is every pixel hitting its limit on one engine
	initial
	begin
		longint budget;
		budget = 0;
		for (int i = 0; i < N_CASES; i++)
			budget += N_PIXELS * (int'(CASES[i].cfg.max_iter) + 4);
		budget = budget * 4;
		repeat (budget) @(posedge tb_clk);
		$display("Timeout: done never came within %0d cycles", budget);
		$display("TEST FAIL");
		$fatal(1, "watchdog expired");
	end

endmodule

// ==== sim.f ====
+incdir+dv
verilog/mandel_pkg.sv
verilog/mandel_iter_core.sv
verilog/mandel_scan_sched.sv
verilog/wb_rr_arbiter.sv
verilog/frame_ram.sv
verilog/mandel_renderer.sv
dv/tb_mandel_renderer.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= tb_mandel_renderer
FILELIST ?= sim.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing -Wno-fatal
FAIL_PATTERN ?= TEST FAIL
PASS_PATTERN ?= TEST PASS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	-./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_PATTERN)" $(LOG); then \
		echo "simulation reported failure, see $(LOG)"; \
		exit 1; \
	elif ! grep -q "$(PASS_PATTERN)" $(LOG); then \
		echo "simulation ended without a result, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
